// ==== hw/ps2_kbd_pkg.sv ====
package ps2_kbd_pkg;

    // ****************************************
    // scan code views.
    // ****************************************

    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } ps2_nibbles_t;

    // one byte, read whole or as two hex nibbles.
    typedef union packed {
        logic [7:0]   raw;
        ps2_nibbles_t nib;
    } ps2_code_u;

    // release prefix sent before the code of a released key.
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // ****************************************
    // seven-segment patterns.
    // ****************************************

    // active low, bit 6 is segment a, bit 0 is segment g.
    localparam logic [6:0] SEG_BLANK = 7'b111_1111;

    function automatic logic [6:0] seg_hex(input logic [3:0] value);
        logic [6:0] pattern;
        case (value)
            4'h0:    pattern = 7'b000_0001;
            4'h1:    pattern = 7'b100_1111;
            4'h2:    pattern = 7'b001_0010;
            4'h3:    pattern = 7'b000_0110;
            4'h4:    pattern = 7'b100_1100;
            4'h5:    pattern = 7'b010_0100;
            4'h6:    pattern = 7'b010_0000;
            4'h7:    pattern = 7'b000_1111;
            4'h8:    pattern = 7'b000_0000;
            4'h9:    pattern = 7'b000_0100;
            4'hA:    pattern = 7'b000_1000;
            4'hB:    pattern = 7'b110_0000;
            4'hC:    pattern = 7'b011_0001;
            4'hD:    pattern = 7'b100_0010;
            4'hE:    pattern = 7'b011_0000;
            default: pattern = 7'b011_1000;
        endcase
        return pattern;
    endfunction

    // decimal digit, blank above nine.
    function automatic logic [6:0] seg_dec(input logic [7:0] value);
        logic [6:0] pattern;
        if (value < 8'd10) begin
            pattern = seg_hex(value[3:0]);
        end else begin
            pattern = SEG_BLANK;
        end
        return pattern;
    endfunction

endpackage

// ==== hw/ps2_frame_rx.sv ====
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ps2_clk,
    input  logic                   ps2_data,
    output ps2_kbd_pkg::ps2_code_u code,
    output logic                   code_valid,
    output logic                   frame_err
);

    // start, eight data, parity, stop.
    localparam int FRAME_BITS = 11;

    logic [2:0]  clk_sync;
    logic [1:0]  data_sync;
    logic        fall;
    logic        bit_in;
    logic [3:0]  bit_cnt;
    logic [9:0]  shreg;
    logic [10:0] frame;
    logic        last_bit;
    logic        frame_ok;

    // ****************************************
    // line synchronisers.
    // ****************************************

    // idle lines are high, so reset to ones.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // keyboard clock falling edge.
    assign fall   = clk_sync[2] & ~clk_sync[1];
    assign bit_in = data_sync[1];

    // ****************************************
    // frame assembly.
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (fall) begin
            if (last_bit) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // lsb first, so older bits drift toward bit 0.
    always_ff @(posedge clk) begin
        if (fall) begin
            shreg <= {bit_in, shreg[9:1]};
        end
    end

    assign last_bit = fall && (bit_cnt == 4'(FRAME_BITS - 1));
    assign frame    = {bit_in, shreg};

    // start low, stop high, odd parity over data and parity bit.
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            code_valid <= last_bit && frame_ok;
            frame_err  <= last_bit && !frame_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (last_bit) begin
            code.raw <= frame[8:1];
        end
    end

    // one frame ends in exactly one outcome, one cycle long.
    strobe_exclusive_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (code_valid || frame_err) |->
            !(code_valid && frame_err) ##1 !(code_valid || frame_err)
    );

endmodule

// ==== hw/key_event_ctrl.sv ====
`timescale 1ns/1ps

module key_event_ctrl #(
    parameter int COUNT_W = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   code_valid,
    input  ps2_kbd_pkg::ps2_code_u code,
    output logic                   push,
    output ps2_kbd_pkg::ps2_code_u push_code,
    output logic [COUNT_W-1:0]     press_count
);

    import ps2_kbd_pkg::*;

    logic      release_pending;
    ps2_code_u last_make;
    logic      is_break;
    logic      is_make;
    logic      is_new;

    // ****************************************
    // code classification.
    // ****************************************

    assign is_break = (code.raw == BREAK_CODE);

    // the byte after a break prefix names the released key.
    assign is_make = code_valid && !is_break && !release_pending;

    // held keys repeat the same make code.
    assign is_new = (code.raw != last_make.raw);

    // set by a prefix, cleared by whatever byte follows it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            release_pending <= 1'b0;
        end else if (code_valid) begin
            release_pending <= is_break;
        end
    end

    // ****************************************
    // push and press counter.
    // ****************************************

    // last_make starts as the prefix, which is never a make code.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push          <= 1'b0;
            press_count   <= '0;
            last_make.raw <= BREAK_CODE;
        end else begin
            push <= is_make;
            if (is_make) begin
                last_make <= code;
                if (is_new) begin
                    press_count <= press_count + COUNT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_make) begin
            push_code <= code;
        end
    end

    // the count only moves on a received code.
    count_follows_code_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(press_count) |-> $past(code_valid)
    );

endmodule

// ==== hw/scan_fifo.sv ====
`timescale 1ns/1ps

module scan_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  logic                   next_n,
    input  ps2_kbd_pkg::ps2_code_u push_code,
    output ps2_kbd_pkg::ps2_code_u head_code,
    output logic                   ready,
    output logic                   overflow
);

    import ps2_kbd_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_CNT = FIFO_DEPTH[AW:0];

    ps2_code_u   mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] used;
    logic        full;
    logic        do_push;
    logic        do_pop;

    // ****************************************
    // pointers and status.
    // ****************************************

    // extra msb tells full from empty.
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign ready = (wr_ptr != rd_ptr);
    assign used  = wr_ptr - rd_ptr;

    assign do_push = push && !full;
    assign do_pop  = !next_n && ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset.
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // ****************************************
    // storage.
    // ****************************************

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_code;
        end
    end

    assign head_code = mem[rd_ptr[AW-1:0]];

    occupancy_bound_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        used <= FULL_CNT
    );

endmodule

// ==== hw/seg_display.sv ====
`timescale 1ns/1ps

module seg_display #(
    parameter int COUNT_W = 8
) (
    input  ps2_kbd_pkg::ps2_code_u head_code,
    input  logic                   ready,
    input  logic [COUNT_W-1:0]     press_count,
    output logic [6:0]             seg0,
    output logic [6:0]             seg1,
    output logic [6:0]             seg2,
    output logic [6:0]             seg3,
    output logic [6:0]             seg4,
    output logic [6:0]             seg5
);

    import ps2_kbd_pkg::*;

    logic [6:0] code_mod;
    logic [6:0] cnt_mod;
    logic [7:0] code_units;
    logic [7:0] code_tens;
    logic [7:0] cnt_units;
    logic [7:0] cnt_tens;

    // ****************************************
    // decimal split.
    // ****************************************

    // both values shown modulo 100.
    assign code_mod = 7'(head_code.raw % 8'd100);
    assign cnt_mod  = 7'(press_count % 100);

    assign code_units = 8'(code_mod % 7'd10);
    assign code_tens  = 8'(code_mod / 7'd10);
    assign cnt_units  = 8'(cnt_mod % 7'd10);
    assign cnt_tens   = 8'(cnt_mod / 7'd10);

    // ****************************************
    // digit drivers.
    // ****************************************

    // code digits go dark when nothing is queued.
    always_comb begin
        if (ready) begin
            seg0 = seg_hex(head_code.nib.lo);
            seg1 = seg_hex(head_code.nib.hi);
            seg2 = seg_dec(code_units);
            seg3 = seg_dec(code_tens);
        end else begin
            seg0 = SEG_BLANK;
            seg1 = SEG_BLANK;
            seg2 = SEG_BLANK;
            seg3 = SEG_BLANK;
        end
    end

    // press count always lit.
    assign seg4 = seg_dec(cnt_units);
    assign seg5 = seg_dec(cnt_tens);

endmodule

// ==== hw/ps2_kbd_top.sv ====
`timescale 1ns/1ps

module ps2_kbd_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int COUNT_W    = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ps2_clk,
    input  logic                   ps2_data,
    input  logic                   next_n,
    output logic                   ready,
    output logic                   overflow,
    output logic                   frame_err,
    output ps2_kbd_pkg::ps2_code_u head_code,
    output logic [6:0]             seg0,
    output logic [6:0]             seg1,
    output logic [6:0]             seg2,
    output logic [6:0]             seg3,
    output logic [6:0]             seg4,
    output logic [6:0]             seg5
);

    import ps2_kbd_pkg::*;

    ps2_code_u          rx_code;
    logic               code_valid;
    logic               push;
    ps2_code_u          push_code;
    logic [COUNT_W-1:0] press_count;

    // keyboard line receiver.
    ps2_frame_rx rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (rx_code),
        .code_valid (code_valid),
        .frame_err  (frame_err)
    );

    key_event_ctrl #(
        .COUNT_W (COUNT_W)
    ) ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .code_valid  (code_valid),
        .code        (rx_code),
        .push        (push),
        .push_code   (push_code),
        .press_count (press_count)
    );

    scan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .next_n    (next_n),
        .push_code (push_code),
        .head_code (head_code),
        .ready     (ready),
        .overflow  (overflow)
    );

    seg_display #(
        .COUNT_W (COUNT_W)
    ) disp_i (
        .head_code   (head_code),
        .ready       (ready),
        .press_count (press_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

endmodule

// ==== verif/ps2_kbd_tb.sv ====
`timescale 1ns/1ps

module ps2_kbd_tb;

    import ps2_kbd_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int COUNT_W    = 8;
    localparam int HALF_BIT   = 10;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [6:0] DARK = 7'b111_1111;

    logic               clk;
    logic               rst_n;
    logic               ps2_clk;
    logic               ps2_data;
    logic               next_n;
    logic               ready;
    logic               overflow;
    logic               frame_err;
    ps2_code_u          head_code;
    logic [6:0]         seg0;
    logic [6:0]         seg1;
    logic [6:0]         seg2;
    logic [6:0]         seg3;
    logic [6:0]         seg4;
    logic [6:0]         seg5;

    logic [31:0]        lfsr_state;
    logic [COUNT_W-1:0] model_count;
    logic [7:0]         model_last;
    logic [7:0]         sent_q [$];

    ps2_kbd_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .COUNT_W    (COUNT_W)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .next_n    (next_n),
        .ready     (ready),
        .overflow  (overflow),
        .frame_err (frame_err),
        .head_code (head_code),
        .seg0      (seg0),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3),
        .seg4      (seg4),
        .seg5      (seg5)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ****************************************
    // helpers and models.
    // ****************************************

    // active low, a in bit 6 down to g in bit 0.
    function automatic logic [6:0] digit_shape(input logic [3:0] value);
        logic [6:0] pattern;
        case (value)
            4'h0:    pattern = 7'b000_0001;
            4'h1:    pattern = 7'b100_1111;
            4'h2:    pattern = 7'b001_0010;
            4'h3:    pattern = 7'b000_0110;
            4'h4:    pattern = 7'b100_1100;
            4'h5:    pattern = 7'b010_0100;
            4'h6:    pattern = 7'b010_0000;
            4'h7:    pattern = 7'b000_1111;
            4'h8:    pattern = 7'b000_0000;
            4'h9:    pattern = 7'b000_0100;
            4'hA:    pattern = 7'b000_1000;
            4'hB:    pattern = 7'b110_0000;
            4'hC:    pattern = 7'b011_0001;
            4'hD:    pattern = 7'b100_0010;
            4'hE:    pattern = 7'b011_0000;
            default: pattern = 7'b011_1000;
        endcase
        return pattern;
    endfunction

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_make(output logic [7:0] code);
        code = 8'hF0;
        while (code == 8'hF0) begin
            for (int i = 0; i < 8; i++) begin
                lfsr_state = lfsr_next(lfsr_state);
                code = {code[6:0], lfsr_state[0]};
            end
        end
    endtask

    // counts a press only when the make code changes.
    task automatic note_make(input logic [7:0] code);
        if (code != model_last) begin
            model_count = model_count + 1'b1;
        end
        model_last = code;
    endtask

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input ps2_code_u expected,
                              input ps2_code_u actual);
        if (actual.raw !== expected.raw) begin
            $display("Fail at %0t ns: %s expected %h actual %h", $time, name,
                     expected.raw, actual.raw);
            abort_run();
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] expected,
                             input logic [6:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_code_digits(input ps2_code_u code);
        int v;
        v = code.raw % 100;
        check_seg("seg0", digit_shape(code.nib.lo), seg0);
        check_seg("seg1", digit_shape(code.nib.hi), seg1);
        check_seg("seg2", digit_shape(4'(v % 10)), seg2);
        check_seg("seg3", digit_shape(4'(v / 10)), seg3);
    endtask

    task automatic check_blank_digits();
        check_seg("seg0", DARK, seg0);
        check_seg("seg1", DARK, seg1);
        check_seg("seg2", DARK, seg2);
        check_seg("seg3", DARK, seg3);
    endtask

    task automatic check_count_digits();
        int v;
        v = model_count % 100;
        check_seg("seg4", digit_shape(4'(v % 10)), seg4);
        check_seg("seg5", digit_shape(4'(v / 10)), seg5);
    endtask

    // ****************************************
    // bus drivers and waits.
    // ****************************************

    // start, data lsb first, odd parity, stop.
    task automatic send_frame(input logic [7:0] data, input logic corrupt);
        logic [10:0] bits;
        logic        parity;
        parity = ~(^data);
        if (corrupt) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            step_cycles(HALF_BIT);
            ps2_clk = 1'b0;
            step_cycles(HALF_BIT);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        step_cycles(HALF_BIT);
    endtask

    task automatic pop_code();
        next_n = 1'b0;
        step_cycles(1);
        next_n = 1'b1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < WAIT_LIMIT) begin
            step_cycles(1);
            n++;
        end
        if (!ready) begin
            $display("timeout: ready never rose");
            abort_run();
        end
    endtask

    task automatic wait_err_pulse();
        int n;
        n = 0;
        while (!frame_err && n < WAIT_LIMIT) begin
            step_cycles(1);
            n++;
        end
        if (!frame_err) begin
            $display("timeout: no frame_err pulse for a bad frame");
            abort_run();
        end
    endtask

    // ****************************************
    // tests.
    // ****************************************

    task automatic test_receive_display();
        ps2_code_u exp;
        check_bit("ready", 1'b0, ready);
        check_blank_digits();
        check_count_digits();
        exp.raw = 8'h1C;
        send_frame(exp.raw, 1'b0);
        note_make(exp.raw);
        wait_ready();
        check_code("head_code", exp, head_code);
        check_code_digits(exp);
        check_count_digits();
        pop_code();
        check_bit("ready", 1'b0, ready);
        check_blank_digits();
    endtask

    task automatic test_break_sequence();
        ps2_code_u exp;
        exp.raw = 8'h1C;
        send_frame(exp.raw, 1'b0);
        note_make(exp.raw);
        send_frame(8'hF0, 1'b0);
        send_frame(exp.raw, 1'b0);
        wait_ready();
        check_code("head_code", exp, head_code);
        check_count_digits();
        pop_code();
        // the released key must not be queued.
        check_bit("ready", 1'b0, ready);
    endtask

    task automatic test_repeat_filter();
        logic [7:0] c;
        ps2_code_u  exp;
        sent_q.delete();
        for (int i = 0; i < 5; i++) begin
            // entry 2 repeats entry 1.
            if (i != 2) begin
                random_make(c);
            end
            send_frame(c, 1'b0);
            note_make(c);
            sent_q.push_back(c);
        end
        while (sent_q.size() > 0) begin
            exp.raw = sent_q.pop_front();
            wait_ready();
            check_code("head_code", exp, head_code);
            check_code_digits(exp);
            pop_code();
        end
        check_bit("ready", 1'b0, ready);
        check_count_digits();
    endtask

    task automatic test_bad_frame();
        fork
            send_frame(8'h2A, 1'b1);
            wait_err_pulse();
        join
        // the error strobe is a single cycle.
        check_bit("frame_err", 1'b0, frame_err);
        check_bit("ready", 1'b0, ready);
        check_blank_digits();
        check_count_digits();
    endtask

    task automatic test_overflow();
        logic [7:0] c;
        ps2_code_u  exp;
        sent_q.delete();
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            random_make(c);
            send_frame(c, 1'b0);
            note_make(c);
            sent_q.push_back(c);
            if (i == FIFO_DEPTH - 1) begin
                check_bit("overflow", 1'b0, overflow);
            end
        end
        check_bit("overflow", 1'b1, overflow);
        check_count_digits();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            exp.raw = sent_q.pop_front();
            wait_ready();
            check_code("head_code", exp, head_code);
            pop_code();
        end
        check_bit("ready", 1'b0, ready);
        check_bit("overflow", 1'b1, overflow);
    endtask

    initial begin
        rst_n       = 1'b0;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        next_n      = 1'b1;
        lfsr_state  = 32'h7d5c;
        model_count = '0;
        model_last  = 8'hF0;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        step_cycles(1);

        test_receive_display();
        test_break_sequence();
        test_repeat_filter();
        test_bad_frame();
        test_overflow();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
hw/ps2_kbd_pkg.sv
hw/ps2_frame_rx.sv
hw/key_event_ctrl.sv
hw/scan_fifo.sv
hw/seg_display.sv
hw/ps2_kbd_top.sv
verif/ps2_kbd_tb.sv

// ==== Bender.yml ====
package:
  name: ps2_kbd

sources:
  - files:
      - hw/ps2_kbd_pkg.sv
      - hw/ps2_frame_rx.sv
      - hw/key_event_ctrl.sv
      - hw/scan_fifo.sv
      - hw/seg_display.sv
      - hw/ps2_kbd_top.sv
  - target: test
    files:
      - verif/ps2_kbd_tb.sv
